// ==== verilog/dac_rx_consts.svh ====
`ifndef DAC_RX_CONSTS_SVH
`define DAC_RX_CONSTS_SVH

// Legal frame length in SCK cycles
`define DAC_FRAME_BITS 32
// Bit counter width, room for the saturated overlong value
`define DAC_CNT_W 6

// Command nibble
`define DAC_CMD_MSB 23
`define DAC_CMD_LSB 20
// Address nibble
`define DAC_ADDR_MSB 19
`define DAC_ADDR_LSB 16
// 12-bit code, low nibble of the frame is don't care
`define DAC_CODE_MSB 15
`define DAC_CODE_LSB 4

// Minimum synchronized low time of the clear line, in DAC_CS cycles
`define DAC_CLR_MIN_CYCLES 4
// Flops per pin synchronizer
`define DAC_SYNC_STAGES 2

`endif

// ==== verilog/dac_rx_pkg.sv ====
`include "dac_rx_consts.svh"

package dac_rx_pkg;

   // Command nibble values of the serial word
   typedef enum logic [3:0] {
      CMD_WRITE_INPUT      = 4'b0000,
      CMD_UPDATE           = 4'b0001,
      CMD_WRITE_UPDATE_ALL = 4'b0010,
      // The only command this receiver accepts
      CMD_WRITE_UPDATE     = 4'b0011,
      CMD_POWER_DOWN       = 4'b0100,
      CMD_NOP              = 4'b1111
   } dac_cmd_e;

   // Channel select nibble
   typedef enum logic [3:0] {
      ADDR_A   = 4'd0,
      ADDR_B   = 4'd1,
      ADDR_C   = 4'd2,
      ADDR_D   = 4'd3,
      ADDR_ALL = 4'd15
   } dac_addr_e;

   // One status code per finished frame
   typedef enum logic [2:0] {
      ST_OK       = 3'd0,
      ST_NOT_INIT = 3'd1,
      ST_SHORT    = 3'd2,
      ST_LONG     = 3'd3,
      ST_BAD_CMD  = 3'd4,
      ST_BAD_ADDR = 3'd5
   } dac_status_e;

   // Shift word and bit count as seen at the end of a frame
   typedef struct packed {
      logic [`DAC_FRAME_BITS-1:0] word;
      logic [`DAC_CNT_W-1:0]      count;
   } frame_t;

   // Link state from the select and clear pins
   typedef struct packed {
      logic sel_active;
      logic frame_start;
      logic frame_end;
      logic clear;
      logic inited;
   } link_t;

   // Current code of each output channel
   typedef struct packed {
      logic [`DAC_CODE_MSB-`DAC_CODE_LSB:0] a;
      logic [`DAC_CODE_MSB-`DAC_CODE_LSB:0] b;
      logic [`DAC_CODE_MSB-`DAC_CODE_LSB:0] c;
      logic [`DAC_CODE_MSB-`DAC_CODE_LSB:0] d;
   } chan_codes_t;

endpackage

// ==== verilog/spi_frame_shifter.sv ====
`timescale 1ns/1ps
`include "dac_rx_consts.svh"

module spi_frame_shifter import dac_rx_pkg::*; (
   input  logic   DAC_CS,
   input  logic   rst_n,
   input  logic   spi_sck,
   input  logic   spi_mosi,
   input  link_t  link,
   output frame_t frame,
   output logic   dac_out
);

   // Count stops one past a legal frame so long frames stay visible
   localparam logic [`DAC_CNT_W-1:0] CNT_MAX = `DAC_CNT_W'(`DAC_FRAME_BITS + 1);

   logic [`DAC_SYNC_STAGES-1:0] sck_sync;
   logic [`DAC_SYNC_STAGES-1:0] mosi_sync;
   logic                        sck_d;
   logic                        sck_rise;
   logic                        shift_en;
   logic [`DAC_FRAME_BITS-1:0]  word;
   logic [`DAC_CNT_W-1:0]       count;

   // Pin synchronizers, mosi runs through the same depth as sck
   always_ff @(posedge DAC_CS) begin
      if (!rst_n) begin
         sck_sync  <= '0;
         mosi_sync <= '0;
         sck_d     <= 1'b0;
      end else begin
         sck_sync  <= {sck_sync[`DAC_SYNC_STAGES-2:0], spi_sck};
         mosi_sync <= {mosi_sync[`DAC_SYNC_STAGES-2:0], spi_mosi};
         sck_d     <= sck_sync[`DAC_SYNC_STAGES-1];
      end
   end

   // Rising SCK in the system clock domain
   assign sck_rise = sck_sync[`DAC_SYNC_STAGES-1] & ~sck_d;
   // Bits only count while the frame is selected
   assign shift_en = sck_rise & link.sel_active;

   // Shift register, MSB first, new bit enters at bit 0
   always_ff @(posedge DAC_CS) begin
      if (!rst_n) begin
         word <= '0;
      end else if (link.clear) begin
         word <= '0;
      end else if (shift_en) begin
         word <= {word[`DAC_FRAME_BITS-2:0], mosi_sync[`DAC_SYNC_STAGES-1]};
      end
   end

   // Bit counter, restarted by each falling select
   always_ff @(posedge DAC_CS) begin
      if (!rst_n) begin
         count <= '0;
      end else if (link.frame_start) begin
         count <= '0;
      end else if (shift_en && count != CNT_MAX) begin
         count <= count + 1'b1;
      end
   end

   assign frame = '{word: word, count: count};

   // Daisy-chain output, quiet outside a frame
   assign dac_out = link.sel_active ? word[`DAC_FRAME_BITS-1] : 1'b0;

endmodule

// ==== verilog/dac_link_guard.sv ====
`timescale 1ns/1ps
`include "dac_rx_consts.svh"

module dac_link_guard import dac_rx_pkg::*; (
   input  logic  DAC_CS,
   input  logic  rst_n,
   input  logic  dac_sel_n,
   input  logic  dac_clr_n,
   output link_t link
);

   // Counter just wide enough to reach the minimum clear time
   localparam int CLR_CNT_W = $clog2(`DAC_CLR_MIN_CYCLES + 1);
   localparam logic [CLR_CNT_W-1:0] CLR_MIN = CLR_CNT_W'(`DAC_CLR_MIN_CYCLES);

   logic [`DAC_SYNC_STAGES-1:0] sel_sync;
   logic [`DAC_SYNC_STAGES-1:0] clr_sync;
   logic                        sel_s;
   logic                        clr_s;
   logic                        sel_d;
   logic [CLR_CNT_W-1:0]        clr_cnt;
   logic                        clr_done;
   logic                        sel_active_q;
   logic                        frame_start_q;
   logic                        frame_end_q;
   logic                        clear_q;
   logic                        inited_q;

   // Both pins idle high, so the synchronizers reset to ones
   always_ff @(posedge DAC_CS) begin
      if (!rst_n) begin
         sel_sync <= '1;
         clr_sync <= '1;
      end else begin
         sel_sync <= {sel_sync[`DAC_SYNC_STAGES-2:0], dac_sel_n};
         clr_sync <= {clr_sync[`DAC_SYNC_STAGES-2:0], dac_clr_n};
      end
   end

   assign sel_s = sel_sync[`DAC_SYNC_STAGES-1];
   assign clr_s = clr_sync[`DAC_SYNC_STAGES-1];

   // Select edges, registered into single-cycle pulses
   always_ff @(posedge DAC_CS) begin
      if (!rst_n) begin
         sel_d         <= 1'b1;
         sel_active_q  <= 1'b0;
         frame_start_q <= 1'b0;
         frame_end_q   <= 1'b0;
      end else begin
         sel_d         <= sel_s;
         sel_active_q  <= ~sel_s;
         frame_start_q <= sel_d & ~sel_s;
         frame_end_q   <= ~sel_d & sel_s;
      end
   end

   // Length of the current low phase on the clear line, saturating
   always_ff @(posedge DAC_CS) begin
      if (!rst_n) begin
         clr_cnt <= '0;
      end else if (clr_s) begin
         clr_cnt <= '0;
      end else if (clr_cnt != CLR_MIN) begin
         clr_cnt <= clr_cnt + 1'b1;
      end
   end

   // Clear takes effect when a long enough low phase ends
   assign clr_done = clr_s & (clr_cnt == CLR_MIN);

   // Part needs one clear after power-up before frames count
   always_ff @(posedge DAC_CS) begin
      if (!rst_n) begin
         clear_q  <= 1'b0;
         inited_q <= 1'b0;
      end else begin
         clear_q <= clr_done;
         if (clr_done) inited_q <= 1'b1;
      end
   end

   assign link = '{sel_active:  sel_active_q,
                   frame_start: frame_start_q,
                   frame_end:   frame_end_q,
                   clear:       clear_q,
                   inited:      inited_q};

endmodule

// ==== verilog/dac_cmd_decoder.sv ====
`timescale 1ns/1ps
`include "dac_rx_consts.svh"

module dac_cmd_decoder import dac_rx_pkg::*; (
   input  logic        DAC_CS,
   input  logic        rst_n,
   input  link_t       link,
   input  frame_t      frame,
   output chan_codes_t codes,
   output logic        status_valid,
   output dac_status_e status
);

   localparam logic [`DAC_CNT_W-1:0] FRAME_LEN = `DAC_CNT_W'(`DAC_FRAME_BITS);

   // REPORT lasts one cycle per finished frame
   typedef enum logic {
      IDLE,
      REPORT
   } dec_state_e;

   dec_state_e                           state;
   dac_status_e                          status_q;
   dac_status_e                          status_next;
   chan_codes_t                          codes_q;
   dac_cmd_e                             cmd_f;
   dac_addr_e                            addr_f;
   logic [`DAC_CODE_MSB-`DAC_CODE_LSB:0] code_f;
   logic                                 addr_ok;

   // Fields of the captured word
   assign cmd_f  = dac_cmd_e'(frame.word[`DAC_CMD_MSB:`DAC_CMD_LSB]);
   assign addr_f = dac_addr_e'(frame.word[`DAC_ADDR_MSB:`DAC_ADDR_LSB]);
   assign code_f = frame.word[`DAC_CODE_MSB:`DAC_CODE_LSB];

   // Addresses 4 to 14 select nothing
   assign addr_ok = addr_f inside {ADDR_A, ADDR_B, ADDR_C, ADDR_D, ADDR_ALL};

   // First failing check decides the status
   always_comb begin
      if (!link.inited) begin
         status_next = ST_NOT_INIT;
      end else if (frame.count > FRAME_LEN) begin
         status_next = ST_LONG;
      end else if (frame.count < FRAME_LEN) begin
         status_next = ST_SHORT;
      end else if (cmd_f != CMD_WRITE_UPDATE) begin
         status_next = ST_BAD_CMD;
      end else if (!addr_ok) begin
         status_next = ST_BAD_ADDR;
      end else begin
         status_next = ST_OK;
      end
   end

   // Status register and the report FSM
   always_ff @(posedge DAC_CS) begin
      if (!rst_n) begin
         state    <= IDLE;
         status_q <= ST_OK;
      end else begin
         // Every frame end opens one REPORT cycle
         state <= link.frame_end ? REPORT : IDLE;
         if (link.frame_end) begin
            status_q <= status_next;
         end
      end
   end

   // Clear wins over a write in the same cycle
   always_ff @(posedge DAC_CS) begin
      if (!rst_n) begin
         codes_q <= '0;
      end else if (link.clear) begin
         codes_q <= '0;
      end else if (link.frame_end && status_next == ST_OK) begin
         case (addr_f)
            ADDR_A: codes_q.a <= code_f;
            ADDR_B: codes_q.b <= code_f;
            ADDR_C: codes_q.c <= code_f;
            ADDR_D: codes_q.d <= code_f;
            // Broadcast write
            default: begin
               codes_q.a <= code_f;
               codes_q.b <= code_f;
               codes_q.c <= code_f;
               codes_q.d <= code_f;
            end
         endcase
      end
   end

   assign codes        = codes_q;
   assign status       = status_q;
   assign status_valid = (state == REPORT);

endmodule

// ==== verilog/dac_rx_top.sv ====
`timescale 1ns/1ps

module dac_rx_top import dac_rx_pkg::*; (
   input  logic        DAC_CS,
   input  logic        rst_n,
   input  logic        spi_sck,
   input  logic        spi_mosi,
   input  logic        dac_sel_n,
   input  logic        dac_clr_n,
   output logic        dac_out,
   output chan_codes_t codes,
   output logic        status_valid,
   output dac_status_e status
);

   // Select level, frame edges, clear and init state
   link_t  link_w;
   // Word and bit count from the shifter
   frame_t frame_w;

   // Bit capture and chain output
   spi_frame_shifter u_shifter (
      .DAC_CS   (DAC_CS),
      .rst_n    (rst_n),
      .spi_sck  (spi_sck),
      .spi_mosi (spi_mosi),
      .link     (link_w),
      .frame    (frame_w),
      .dac_out  (dac_out)
   );

   // Select and clear tracking, owns the select synchronizer
   dac_link_guard u_guard (
      .DAC_CS    (DAC_CS),
      .rst_n     (rst_n),
      .dac_sel_n (dac_sel_n),
      .dac_clr_n (dac_clr_n),
      .link      (link_w)
   );

   // Frame checks and channel registers
   dac_cmd_decoder u_decoder (
      .DAC_CS       (DAC_CS),
      .rst_n        (rst_n),
      .link         (link_w),
      .frame        (frame_w),
      .codes        (codes),
      .status_valid (status_valid),
      .status       (status)
   );

endmodule

// ==== dv/dac_rx_properties.sv ====
`timescale 1ns/1ps

module dac_rx_properties import dac_rx_pkg::*; (
   input logic        DAC_CS,
   input logic        rst_n,
   input logic        dac_sel_n,
   input link_t       link,
   input logic        status_valid,
   input logic        dac_out,
   input chan_codes_t codes
);

   // Status pulse lasts one cycle
   a_status_single: assert property (
      @(posedge DAC_CS) disable iff (!rst_n) status_valid |=> !status_valid)
      else $error("status_valid stayed high for more than one cycle");

   // Every frame end is reported on the next cycle
   a_status_after_end: assert property (
      @(posedge DAC_CS) disable iff (!rst_n) link.frame_end |=> status_valid)
      else $error("no status_valid one cycle after frame_end");

   // And no report without a frame end just before
   a_status_has_cause: assert property (
      @(posedge DAC_CS) disable iff (!rst_n) status_valid |-> $past(link.frame_end))
      else $error("status_valid without a preceding frame_end");

   // Pin select high three edges back means the synchronized select is idle
   a_chain_quiet: assert property (
      @(posedge DAC_CS) disable iff (!rst_n) $past(dac_sel_n, 3) |-> !dac_out)
      else $error("dac_out high while select is inactive");

   // Outputs at reset values as reset is released
   a_reset_values: assert property (
      @(posedge DAC_CS) $rose(rst_n) |->
         (!status_valid && codes == '0 && !link.inited && !dac_out))
      else $error("outputs not at reset values after reset");

endmodule

// ==== dv/dac_rx_tb.sv ====
`timescale 1ns/1ps
`include "dac_rx_consts.svh"

module dac_rx_tb import dac_rx_pkg::*; ();

   // SCK level hold in DAC_CS cycles
   localparam int SCK_HOLD       = 4;
   localparam int STATUS_TIMEOUT = 200;

   logic        DAC_CS;
   logic        rst_n;
   logic        spi_sck;
   logic        spi_mosi;
   logic        dac_sel_n;
   logic        dac_clr_n;
   logic        dac_out;
   chan_codes_t codes;
   logic        status_valid;
   dac_status_e status;

   // Reference model of the channel codes
   chan_codes_t exp_codes;
   int          errors;
   int          checks;
   int          tests;

   always #20 DAC_CS = ~DAC_CS;

   dac_rx_top u_dut (
      .DAC_CS       (DAC_CS),
      .rst_n        (rst_n),
      .spi_sck      (spi_sck),
      .spi_mosi     (spi_mosi),
      .dac_sel_n    (dac_sel_n),
      .dac_clr_n    (dac_clr_n),
      .dac_out      (dac_out),
      .codes        (codes),
      .status_valid (status_valid),
      .status       (status)
   );

   // Properties see the internal link flags
   bind dac_rx_top dac_rx_properties u_props (
      .DAC_CS       (DAC_CS),
      .rst_n        (rst_n),
      .dac_sel_n    (dac_sel_n),
      .link         (link_w),
      .status_valid (status_valid),
      .dac_out      (dac_out),
      .codes        (codes)
   );

   // Frame word with command, address and code at their field positions
   function automatic logic [`DAC_FRAME_BITS-1:0] make_word(input logic [3:0] cmd,
                                                          input logic [3:0] addr,
                                                          input logic [11:0] code);
      logic [`DAC_FRAME_BITS-1:0] w;
      w = '0;
      // Don't-care high byte carries ones and zeros out on the chain
      w[`DAC_FRAME_BITS-1:`DAC_CMD_MSB+1] = 8'hA5;
      w[`DAC_CMD_MSB:`DAC_CMD_LSB]   = cmd;
      w[`DAC_ADDR_MSB:`DAC_ADDR_LSB] = addr;
      w[`DAC_CODE_MSB:`DAC_CODE_LSB] = code;
      return w;
   endfunction

   // Accepted write to one channel or to all four
   function automatic void apply_write(input logic [3:0] addr, input logic [11:0] code);
      case (addr)
         4'd0:    exp_codes.a = code;
         4'd1:    exp_codes.b = code;
         4'd2:    exp_codes.c = code;
         4'd3:    exp_codes.d = code;
         4'd15:   exp_codes = {4{code}};
         default: exp_codes = exp_codes;
      endcase
   endfunction

   task automatic check_value(input logic [47:0] got, input logic [47:0] exp,
                              input string what);
      checks++;
      assert (got === exp) else begin
         $display("FAIL %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
         errors++;
      end
   endtask

   // Drives one frame MSB first and optionally checks the chain output
   task automatic send_frame(input logic [63:0] bits, input int nbits, input logic chain_chk,
                             input logic [31:0] prev_word);
      int i;
      int k;
      @(posedge DAC_CS);
      dac_sel_n <= 1'b0;
      spi_sck   <= 1'b0;
      // Synchronized select must be active before the first SCK edge
      repeat (SCK_HOLD) @(posedge DAC_CS);
      for (i = nbits - 1; i >= 0; i--) begin
         k = nbits - 1 - i;
         spi_mosi <= bits[i];
         repeat (SCK_HOLD - 1) @(posedge DAC_CS);
         // Before edge k the chain shows bit k of the previous word
         if (chain_chk && k < 32) begin
            @(negedge DAC_CS);
            check_value(48'(dac_out), 48'(prev_word[31 - k]), "dac_out during frame");
         end
         @(posedge DAC_CS);
         spi_sck <= 1'b1;
         repeat (SCK_HOLD) @(posedge DAC_CS);
         spi_sck <= 1'b0;
      end
      repeat (SCK_HOLD) @(posedge DAC_CS);
      dac_sel_n <= 1'b1;
      spi_mosi  <= 1'b0;
   endtask

   task automatic wait_status(output logic got, output dac_status_e st);
      int n;
      got = 1'b0;
      st  = ST_OK;
      for (n = 0; n < STATUS_TIMEOUT && !got; n++) begin
         @(negedge DAC_CS);
         if (status_valid) begin
            got = 1'b1;
            st  = status;
         end
      end
   endtask

   // Sends a frame and checks status, codes and the quiet chain output
   task automatic run_frame(input logic [63:0] bits, input int nbits,
                            input dac_status_e exp_st, input logic chain_chk,
                            input logic [31:0] prev_word, input string what);
      logic        got;
      dac_status_e st;
      if (exp_st == ST_OK)
         apply_write(bits[`DAC_ADDR_MSB:`DAC_ADDR_LSB], bits[`DAC_CODE_MSB:`DAC_CODE_LSB]);
      send_frame(bits, nbits, chain_chk, prev_word);
      wait_status(got, st);
      if (!got) begin
         $display("Timeout at %0t ns: %s got no status pulse within %0d cycles",
                  $time, what, STATUS_TIMEOUT);
         errors++;
      end else begin
         check_value(48'(st), 48'(exp_st), {what, ": status"});
         check_value(codes, exp_codes, {what, ": channel codes"});
         check_value(48'(dac_out), 48'(0), {what, ": dac_out after frame"});
      end
   endtask

   task automatic pulse_clear(input int low_cycles);
      @(posedge DAC_CS);
      dac_clr_n <= 1'b0;
      repeat (low_cycles) @(posedge DAC_CS);
      dac_clr_n <= 1'b1;
   endtask

   task automatic finish_test(input string name, input int err0);
      tests++;
      $display("test %s done, %0d errors", name, errors - err0);
   endtask

   // No writes before a full-width clear and none after a glitch
   task automatic require_init();
      int          err0;
      logic [31:0] w;
      err0 = errors;
      w    = make_word(CMD_WRITE_UPDATE, ADDR_A, 12'hABC);
      run_frame({32'h0, w}, 32, ST_NOT_INIT, 1'b0, '0, "frame before clear");
      pulse_clear(2);
      run_frame({32'h0, w}, 32, ST_NOT_INIT, 1'b0, '0, "frame after clear glitch");
      pulse_clear(`DAC_CLR_MIN_CYCLES);
      run_frame({32'h0, w}, 32, ST_OK, 1'b0, '0, "frame after full clear");
      finish_test("init_required", err0);
   endtask

   // Each channel alone, then the broadcast address
   task automatic write_channels();
      int          err0;
      int          a;
      logic [11:0] code;
      err0 = errors;
      for (a = 0; a < 4; a++) begin
         code = 12'($urandom());
         run_frame({32'h0, make_word(CMD_WRITE_UPDATE, 4'(a), code)}, 32, ST_OK, 1'b0, '0,
                   $sformatf("write channel %0d", a));
      end
      code = 12'($urandom());
      run_frame({32'h0, make_word(CMD_WRITE_UPDATE, ADDR_ALL, code)}, 32, ST_OK, 1'b0, '0,
                "broadcast write");
      finish_test("channel_writes", err0);
   endtask

   // Short and long frames leave the codes untouched
   task automatic reject_bad_lengths();
      int          err0;
      logic [31:0] w;
      err0 = errors;
      w    = make_word(CMD_WRITE_UPDATE, ADDR_B, 12'h5A5);
      run_frame({33'h0, w[30:0]}, 31, ST_SHORT, 1'b0, '0, "31-bit frame");
      run_frame({24'h0, 8'hC3, w}, 40, ST_LONG, 1'b0, '0, "40-bit frame");
      finish_test("bad_length", err0);
   endtask

   // Wrong command and unused address
   task automatic reject_bad_fields();
      int err0;
      err0 = errors;
      run_frame({32'h0, make_word(4'b0001, ADDR_B, 12'h123)}, 32, ST_BAD_CMD, 1'b0, '0,
                "command 0001");
      run_frame({32'h0, make_word(CMD_WRITE_UPDATE, 4'd5, 12'h321)}, 32, ST_BAD_ADDR, 1'b0,
                '0, "address 5");
      finish_test("bad_fields", err0);
   endtask

   // Second frame shifts the first one out on dac_out
   task automatic shift_out_chain();
      int          err0;
      logic [31:0] x;
      logic [31:0] y;
      err0 = errors;
      x    = make_word(CMD_WRITE_UPDATE, ADDR_C, 12'($urandom()));
      y    = make_word(CMD_WRITE_UPDATE, ADDR_D, 12'($urandom()));
      run_frame({32'h0, x}, 32, ST_OK, 1'b0, '0, "chain first frame");
      run_frame({32'h0, y}, 32, ST_OK, 1'b1, x, "chain second frame");
      finish_test("chain_output", err0);
   endtask

   task automatic clear_after_writes();
      int          err0;
      logic [11:0] code;
      err0 = errors;
      // Nonzero so the clear is visible
      code = 12'($urandom()) | 12'h001;
      run_frame({32'h0, make_word(CMD_WRITE_UPDATE, ADDR_ALL, code)}, 32, ST_OK, 1'b0, '0,
                "write before clear");
      pulse_clear(`DAC_CLR_MIN_CYCLES);
      // Release is sampled on the next edge
      repeat (3) @(posedge DAC_CS);
      @(negedge DAC_CS);
      // Codes still hold the write one edge before the clear lands
      check_value(codes, exp_codes, "codes just before clear");
      @(negedge DAC_CS);
      exp_codes = '0;
      check_value(codes, exp_codes, "codes after clear");
      finish_test("clear_codes", err0);
   endtask

   initial begin
      void'($urandom(67));
      DAC_CS    = 1'b0;
      rst_n     = 1'b0;
      spi_sck   = 1'b0;
      spi_mosi  = 1'b0;
      dac_sel_n = 1'b1;
      dac_clr_n = 1'b1;
      exp_codes = '0;
      errors    = 0;
      checks    = 0;
      tests     = 0;
      repeat (4) @(posedge DAC_CS);
      rst_n <= 1'b1;
      @(negedge DAC_CS);
      check_value(48'(status_valid), 48'(0), "status_valid after reset");
      check_value(codes, '0, "codes after reset");
      check_value(48'(dac_out), 48'(0), "dac_out after reset");
      require_init();
      write_channels();
      reject_bad_lengths();
      reject_bad_fields();
      shift_out_chain();
      clear_after_writes();
      $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+verilog
verilog/dac_rx_pkg.sv
verilog/spi_frame_shifter.sv
verilog/dac_link_guard.sv
verilog/dac_cmd_decoder.sv
verilog/dac_rx_top.sv
dv/dac_rx_properties.sv
dv/dac_rx_tb.sv

// ==== Makefile ====
# Verilator build and run of the DAC serial receiver testbench

TOP := dac_rx_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the verdict"
	@echo "  clean  remove the Verilator build directory"

# The run counts as passed only if the verdict line is in the output
test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
